/* common/rename_pkg.sv */
// Widths, types and reset constants shared by the rename core
package rename_pkg;

	// Register counts
	localparam int NUM_AR = 32;
	localparam int NUM_PR = 64;

	// Default reorder buffer size, power of two
	localparam int ROB_DEPTH = 16;

	// Dispatch, completion and retire width
	localparam int WAYS = 2;

	// Free list holds every tag not mapped after reset
	localparam int FL_DEPTH = NUM_PR - NUM_AR;
	localparam int FL_IDX_W = $clog2(FL_DEPTH);

	typedef logic [4:0] ar_t;          // Architectural register index
	typedef logic [5:0] pr_t;          // Physical register tag
	typedef logic [1:0] way_cnt_t;     // 0 to WAYS
	typedef logic [FL_IDX_W-1:0] fl_idx_t;
	typedef logic [FL_IDX_W:0] fl_ptr_t;   // Extra bit tells full from empty

	// Reset values
	localparam fl_ptr_t FL_HEAD_RST = '0;
	localparam fl_ptr_t FL_TAIL_RST = fl_ptr_t'(FL_DEPTH);  // Queue starts full
	localparam pr_t FL_FIRST_TAG = pr_t'(NUM_AR);
	localparam way_cnt_t RETIRE_NONE = '0;

endpackage

/* verilog/map_table.sv */
// Architectural to physical map table with same-group bypass
`timescale 1ns/1ns

module map_table (
	input  logic                                   clock,
	input  logic                                   rst_n,
	input  logic [rename_pkg::WAYS-1:0]            disp_valid,
	input  rename_pkg::ar_t [rename_pkg::WAYS-1:0] disp_dest,
	input  rename_pkg::pr_t [rename_pkg::WAYS-1:0] alloc_pr,
	output rename_pkg::pr_t [rename_pkg::WAYS-1:0] told
);

	rename_pkg::pr_t mapping [rename_pkg::NUM_AR];
	rename_pkg::pr_t [rename_pkg::WAYS-1:0] told_nxt;

	// Old mapping per lane
	always_comb begin
		told_nxt[0] = mapping[disp_dest[0]];
		if (disp_valid[0] && disp_dest[1] == disp_dest[0]) begin
			told_nxt[1] = alloc_pr[0];  // Lane 0 renamed it first
		end else begin
			told_nxt[1] = mapping[disp_dest[1]];
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < rename_pkg::NUM_AR; i++) begin
				mapping[i] <= rename_pkg::pr_t'(i);   // Identity
			end
		end else begin
			if (disp_valid[0]) begin
				mapping[disp_dest[0]] <= alloc_pr[0];
			end
			// Later write wins on a shared destination
			if (disp_valid[1]) begin
				mapping[disp_dest[1]] <= alloc_pr[1];
			end
		end
	end

	always_ff @(posedge clock) begin
		told <= told_nxt;
	end

	// Lanes fill in order, the ROB and free list rely on it
	assert property (@(posedge clock) disable iff (!rst_n)
		disp_valid[1] |-> disp_valid[0]);

endmodule

/* verilog/free_list.sv */
// Free list of physical tags as a circular queue
`timescale 1ns/1ns

module free_list (
	input  logic                                   clock,
	input  logic                                   rst_n,
	input  logic [rename_pkg::WAYS-1:0]            disp_valid,
	output rename_pkg::pr_t [rename_pkg::WAYS-1:0] alloc_pr,
	input  rename_pkg::way_cnt_t                   retire_num,
	input  rename_pkg::pr_t                        retire_tag_a,
	input  rename_pkg::pr_t                        retire_tag_b
);

	rename_pkg::pr_t slot [rename_pkg::FL_DEPTH];
	rename_pkg::fl_ptr_t head;
	rename_pkg::fl_ptr_t tail;
	rename_pkg::fl_ptr_t fill;
	rename_pkg::fl_idx_t head0;
	rename_pkg::fl_idx_t head1;
	rename_pkg::fl_idx_t tail0;
	rename_pkg::fl_idx_t tail1;
	rename_pkg::way_cnt_t n_pop;

	assign head0 = head[rename_pkg::FL_IDX_W-1:0];
	assign head1 = head0 + rename_pkg::fl_idx_t'(1);
	assign tail0 = tail[rename_pkg::FL_IDX_W-1:0];
	assign tail1 = tail0 + rename_pkg::fl_idx_t'(1);
	assign fill = tail - head;
	assign n_pop = rename_pkg::way_cnt_t'(disp_valid[0]) + rename_pkg::way_cnt_t'(disp_valid[1]);

	// Next two tags offered every cycle
	assign alloc_pr[0] = slot[head0];
	assign alloc_pr[1] = slot[head1];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head <= rename_pkg::FL_HEAD_RST;
			tail <= rename_pkg::FL_TAIL_RST;
			for (int i = 0; i < rename_pkg::FL_DEPTH; i++) begin
				slot[i] <= rename_pkg::FL_FIRST_TAG + rename_pkg::pr_t'(i);
			end
		end else begin
			head <= head + rename_pkg::fl_ptr_t'(n_pop);
			tail <= tail + rename_pkg::fl_ptr_t'(retire_num);
			if (retire_num != rename_pkg::RETIRE_NONE) begin
				slot[tail0] <= retire_tag_a;
			end
			if (retire_num == rename_pkg::way_cnt_t'(rename_pkg::WAYS)) begin
				slot[tail1] <= retire_tag_b;   // Older tag goes first
			end
		end
	end

	// Credits bound the tags in flight, so neither end can run over
	assert property (@(posedge clock) disable iff (!rst_n)
		int'(n_pop) <= int'(fill));

	assert property (@(posedge clock) disable iff (!rst_n)
		int'(fill) - int'(n_pop) + int'(retire_num) <= rename_pkg::FL_DEPTH);

endmodule

/* rob/rob.sv */
// Reorder buffer with CDB completion, two-wide in-order retirement and credit return
`timescale 1ns/1ns

module rob #(
	parameter int rob_depth = rename_pkg::ROB_DEPTH
) (
	input  logic                                   clock,
	input  logic                                   rst_n,

	// Dispatch
	input  logic [rename_pkg::WAYS-1:0]            disp_valid,
	input  rename_pkg::pr_t [rename_pkg::WAYS-1:0] alloc_pr,
	input  rename_pkg::pr_t [rename_pkg::WAYS-1:0] told,   // One cycle after dispatch

	// Completion
	input  logic [rename_pkg::WAYS-1:0]            cdb_valid,
	input  rename_pkg::pr_t [rename_pkg::WAYS-1:0] cdb_tag,

	output logic [rename_pkg::WAYS-1:0]            res_valid,
	output rename_pkg::pr_t [rename_pkg::WAYS-1:0] res_pr,
	output logic [rename_pkg::WAYS-1:0][$clog2(rob_depth)-1:0] res_rob_idx,

	output rename_pkg::way_cnt_t                   retire_num,
	output rename_pkg::pr_t                        retire_tag_a,
	output rename_pkg::pr_t                        retire_tag_b
);

	localparam int idx_w = $clog2(rob_depth);
	localparam int ptr_w = idx_w + 1;

	rename_pkg::pr_t entry_pr [rob_depth];
	rename_pkg::pr_t entry_told [rob_depth];
	logic [rob_depth-1:0] entry_valid;
	logic [rob_depth-1:0] entry_done;

	logic [ptr_w-1:0] head;
	logic [ptr_w-1:0] tail;
	logic [ptr_w-1:0] occ;
	logic [idx_w-1:0] head0;
	logic [idx_w-1:0] head1;
	logic [idx_w-1:0] tail0;
	logic [idx_w-1:0] tail1;

	logic [rename_pkg::WAYS-1:0][rob_depth-1:0] cdb_hit;
	rename_pkg::way_cnt_t n_disp;
	rename_pkg::way_cnt_t n_ret;
	logic ret0;
	logic ret1;

	assign head0 = head[idx_w-1:0];
	assign head1 = head0 + idx_w'(1);
	assign tail0 = tail[idx_w-1:0];
	assign tail1 = tail0 + idx_w'(1);
	assign occ = tail - head;
	assign n_disp = rename_pkg::way_cnt_t'(disp_valid[0]) + rename_pkg::way_cnt_t'(disp_valid[1]);

	// Second entry only behind a finished head
	assign ret0 = entry_valid[head0] & entry_done[head0];
	assign ret1 = ret0 & entry_valid[head1] & entry_done[head1];
	assign n_ret = rename_pkg::way_cnt_t'(ret0) + rename_pkg::way_cnt_t'(ret1);

	// Match broadcast tags against waiting entries
	always_comb begin
		for (int w = 0; w < rename_pkg::WAYS; w++) begin
			for (int i = 0; i < rob_depth; i++) begin
				cdb_hit[w][i] = cdb_valid[w] && entry_valid[i] && !entry_done[i] &&
					entry_pr[i] == cdb_tag[w];
			end
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head        <= '0;
			tail        <= '0;
			entry_valid <= '0;
			entry_done  <= '0;
			retire_num  <= rename_pkg::RETIRE_NONE;
			res_valid   <= '0;
		end else begin
			entry_done <= entry_done | cdb_hit[0] | cdb_hit[1];
			if (ret0) begin
				entry_valid[head0] <= 1'b0;
			end
			if (ret1) begin
				entry_valid[head1] <= 1'b0;
			end
			if (disp_valid[0]) begin
				entry_valid[tail0] <= 1'b1;
				entry_done[tail0]  <= 1'b0;
			end
			if (disp_valid[1]) begin
				entry_valid[tail1] <= 1'b1;
				entry_done[tail1]  <= 1'b0;
			end
			head       <= head + ptr_w'(n_ret);
			tail       <= tail + ptr_w'(n_disp);
			retire_num <= n_ret;     // One credit per entry
			res_valid  <= disp_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (disp_valid[0]) begin
			entry_pr[tail0] <= alloc_pr[0];
		end
		if (disp_valid[1]) begin
			entry_pr[tail1] <= alloc_pr[1];
		end
		// Told lands with the registered result of its entry
		for (int w = 0; w < rename_pkg::WAYS; w++) begin
			if (res_valid[w]) begin
				entry_told[res_rob_idx[w]] <= told[w];
			end
		end
		res_pr         <= alloc_pr;
		res_rob_idx[0] <= tail0;
		res_rob_idx[1] <= tail1;
		retire_tag_a   <= entry_told[head0];
		retire_tag_b   <= entry_told[head1];
	end

	// Sender credits never exceed the free entries
	assert property (@(posedge clock) disable iff (!rst_n)
		int'(occ) + int'(n_disp) <= rob_depth);

	for (genvar w = 0; w < rename_pkg::WAYS; w++) begin : g_cdb_chk
		assert property (@(posedge clock) disable iff (!rst_n)
			cdb_valid[w] |-> $onehot(cdb_hit[w]));
	end

endmodule

/* verilog/rename_core.sv */
// Rename core top: map table, free list and reorder buffer
`timescale 1ns/1ns

module rename_core #(
	parameter int rob_depth = rename_pkg::ROB_DEPTH
) (
	input  logic                                          clock,
	input  logic                                          rst_n,

	// Dispatch, one lane per way
	input  logic [rename_pkg::WAYS-1:0]                   disp_valid,
	input  rename_pkg::ar_t [rename_pkg::WAYS-1:0]        disp_dest,

	// Common data bus
	input  logic [rename_pkg::WAYS-1:0]                   cdb_valid,
	input  rename_pkg::pr_t [rename_pkg::WAYS-1:0]        cdb_tag,

	// Dispatch results, one cycle after dispatch
	output logic [rename_pkg::WAYS-1:0]                   res_valid,
	output rename_pkg::pr_t [rename_pkg::WAYS-1:0]        res_pr,
	output rename_pkg::pr_t [rename_pkg::WAYS-1:0]        res_told,
	output logic [rename_pkg::WAYS-1:0][$clog2(rob_depth)-1:0] res_rob_idx,

	// Retirement, also the credit return
	output rename_pkg::way_cnt_t                          retire_num,
	output rename_pkg::pr_t                               retire_tag_a,
	output rename_pkg::pr_t                               retire_tag_b
);

	rename_pkg::pr_t [rename_pkg::WAYS-1:0] alloc_pr;   // Free list head, comb

	map_table i_map_table (
		.clock      (clock),
		.rst_n      (rst_n),
		.disp_valid (disp_valid),
		.disp_dest  (disp_dest),
		.alloc_pr   (alloc_pr),
		.told       (res_told)
	);

	free_list i_free_list (
		.clock        (clock),
		.rst_n        (rst_n),
		.disp_valid   (disp_valid),
		.alloc_pr     (alloc_pr),
		.retire_num   (retire_num),
		.retire_tag_a (retire_tag_a),
		.retire_tag_b (retire_tag_b)
	);

	rob #(
		.rob_depth (rob_depth)
	) i_rob (
		.clock        (clock),
		.rst_n        (rst_n),
		.disp_valid   (disp_valid),
		.alloc_pr     (alloc_pr),
		.told         (res_told),      // Arrives with res_*, one cycle late
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.res_valid    (res_valid),
		.res_pr       (res_pr),
		.res_rob_idx  (res_rob_idx),
		.retire_num   (retire_num),
		.retire_tag_a (retire_tag_a),
		.retire_tag_b (retire_tag_b)
	);

endmodule

/* tests/rename_model.svh */
// Reference model for the testbench: map table, free tag queue and in-order ROB
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

localparam int NOT_DONE = 32'h7fffffff;

rename_pkg::pr_t map_m [rename_pkg::NUM_AR];
rename_pkg::pr_t free_q [$];
rename_pkg::pr_t rob_pr_q [$];
rename_pkg::pr_t rob_told_q [$];
int rob_done_q [$];    // Cycle of the CDB broadcast
int next_idx;

function automatic void reset_model();
	for (int i = 0; i < rename_pkg::NUM_AR; i++) begin
		map_m[i] = rename_pkg::pr_t'(i);   // Identity
	end
	for (int t = rename_pkg::NUM_AR; t < rename_pkg::NUM_PR; t++) begin
		free_q.push_back(rename_pkg::pr_t'(t));
	end
	next_idx = 0;
endfunction

// Lanes of one group go through in order, so lane 1 sees lane 0's tag
function automatic void rename_lane(input rename_pkg::ar_t dest,
		output rename_pkg::pr_t new_pr, output rename_pkg::pr_t old_pr, output int idx);
	new_pr = free_q.pop_front();
	old_pr = map_m[dest];
	map_m[dest] = new_pr;
	idx = next_idx % rob_depth;
	next_idx++;
	rob_pr_q.push_back(new_pr);
	rob_told_q.push_back(old_pr);
	rob_done_q.push_back(NOT_DONE);
endfunction

// CDB sample, done bit, registered retire: three cycles from broadcast to view
function automatic int retire_count(input int cyc_now);
	int n;
	n = 0;
	while (n < rename_pkg::WAYS && n < rob_done_q.size() && rob_done_q[n] <= cyc_now - 3) begin
		n++;
	end
	return n;
endfunction

function automatic rename_pkg::pr_t retire_front();
	rename_pkg::pr_t t;
	t = rob_told_q.pop_front();
	rob_pr_q.delete(0);
	rob_done_q.delete(0);
	free_q.push_back(t);   // Old tag goes back
	return t;
endfunction

`endif

/* tests/tb_rename_core.sv */
// Testbench for the rename core: clock, reset, random dispatch and completion, checks, timeout
`timescale 1ns/1ns

module tb_rename_core;

	localparam int rob_depth = rename_pkg::ROB_DEPTH;
	localparam int RAND_CYCLES = 600;
	localparam int TIMEOUT_CYCLES = 20 * RAND_CYCLES + 200;
	localparam logic [31:0] SEED = 32'hb01cccee;

	typedef logic [$clog2(rob_depth)-1:0] rob_idx_t;

	logic clock;
	logic rst_n;
	logic [rename_pkg::WAYS-1:0] disp_valid;
	rename_pkg::ar_t [rename_pkg::WAYS-1:0] disp_dest;
	logic [rename_pkg::WAYS-1:0] cdb_valid;
	rename_pkg::pr_t [rename_pkg::WAYS-1:0] cdb_tag;
	logic [rename_pkg::WAYS-1:0] res_valid;
	rename_pkg::pr_t [rename_pkg::WAYS-1:0] res_pr;
	rename_pkg::pr_t [rename_pkg::WAYS-1:0] res_told;
	rob_idx_t [rename_pkg::WAYS-1:0] res_rob_idx;
	rename_pkg::way_cnt_t retire_num;
	rename_pkg::pr_t retire_tag_a;
	rename_pkg::pr_t retire_tag_b;

	int cyc;
	int credits;
	int dispatched_lanes;
	int retired_lanes;
	int zero_credit_cycles;
	int value_errs;
	int other_errs;
	int cycle_cnt = 0;
	int unsigned seed_ret;
	logic [1:0] grp_valid_q [$];       // Groups waiting for their results
	rename_pkg::ar_t grp_dest_q [$];   // Two per group

	`include "rename_model.svh"

	rename_core #(.rob_depth(rob_depth)) i_dut (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("Timeout: ROB not drained within %0d cycles", TIMEOUT_CYCLES);
			$display("Errors: %0d value mismatches, %0d other failures",
				value_errs, other_errs + 1);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic check_pr(input string label, input rename_pkg::pr_t got,
			input rename_pkg::pr_t want);
		if (got !== want) begin
			value_errs++;
			$display("FAIL %0t: %s is %0d, expected %0d", $time, label, got, want);
		end
	endtask

	task automatic check_rob_idx(input rob_idx_t got, input rob_idx_t want);
		if (got !== want) begin
			value_errs++;
			$display("FAIL %0t: ROB index is %0d, expected %0d", $time, got, want);
		end
	endtask

	task automatic check_retire(input rename_pkg::way_cnt_t got_n, input rename_pkg::pr_t got_a,
			input rename_pkg::pr_t got_b, input rename_pkg::way_cnt_t want_n,
			input rename_pkg::pr_t want_a, input rename_pkg::pr_t want_b);
		if (got_n !== want_n || (want_n > 0 && got_a !== want_a) ||
				(want_n > 1 && got_b !== want_b)) begin
			value_errs++;
			$display("FAIL %0t: retired %0d (%0d, %0d), expected %0d (%0d, %0d)", $time,
				got_n, got_a, got_b, want_n, want_a, want_b);
		end
	endtask

	task automatic observe_results();
		logic [1:0] want_v;
		rename_pkg::ar_t dest [2];
		rename_pkg::pr_t new_pr;
		rename_pkg::pr_t old_pr;
		int idx;
		want_v = grp_valid_q.pop_front();
		dest[0] = grp_dest_q.pop_front();
		dest[1] = grp_dest_q.pop_front();
		if (res_valid !== want_v) begin
			value_errs++;
			$display("FAIL %0t: res_valid is %b, expected %b", $time, res_valid, want_v);
		end
		for (int w = 0; w < rename_pkg::WAYS; w++) begin
			if (want_v[w]) begin
				rename_lane(dest[w], new_pr, old_pr, idx);
				check_pr($sformatf("res_pr[%0d]", w), res_pr[w], new_pr);
				check_pr($sformatf("res_told[%0d]", w), res_told[w], old_pr);
				check_rob_idx(res_rob_idx[w], rob_idx_t'(idx));
			end
		end
	endtask

	task automatic observe_retire();
		int n;
		rename_pkg::pr_t want_a;
		rename_pkg::pr_t want_b;
		n = retire_count(cyc);
		want_a = '0;
		want_b = '0;
		if (n > 0) begin
			want_a = retire_front();
		end
		if (n > 1) begin
			want_b = retire_front();
		end
		check_retire(retire_num, retire_tag_a, retire_tag_b,
			rename_pkg::way_cnt_t'(n), want_a, want_b);
		credits += int'(retire_num);   // Credit return
		retired_lanes += int'(retire_num);
	endtask

	task automatic drive_dispatch(input bit allow);
		int n;
		rename_pkg::ar_t d0;
		rename_pkg::ar_t d1;
		n = allow ? int'($urandom % 3) : 0;
		if (credits == 0) begin
			zero_credit_cycles++;
		end
		if (n > credits) begin
			n = credits;
		end
		d0 = rename_pkg::ar_t'($urandom);
		// Shared destination now and then
		d1 = ($urandom % 4 == 0) ? d0 : rename_pkg::ar_t'($urandom);
		credits -= n;
		dispatched_lanes += n;
		disp_valid <= (n == 2) ? 2'b11 : (n == 1) ? 2'b01 : 2'b00;
		disp_dest[0] <= d0;
		disp_dest[1] <= d1;
		grp_valid_q.push_back((n == 2) ? 2'b11 : (n == 1) ? 2'b01 : 2'b00);
		grp_dest_q.push_back(d0);
		grp_dest_q.push_back(d1);
	endtask

	// Broadcast up to two random tags still waiting in the ROB
	task automatic drive_completion();
		int open_q [$];
		int n;
		int pick;
		logic [1:0] v;
		rename_pkg::pr_t tag [2];
		v = '0;
		tag[0] = '0;
		tag[1] = '0;
		for (int i = 0; i < rob_done_q.size(); i++) begin
			if (rob_done_q[i] == NOT_DONE) begin
				open_q.push_back(i);
			end
		end
		n = int'($urandom % 3);
		for (int w = 0; w < rename_pkg::WAYS; w++) begin
			if (w < n && open_q.size() > 0) begin
				pick = int'($urandom % open_q.size());
				tag[w] = rob_pr_q[open_q[pick]];
				rob_done_q[open_q[pick]] = cyc;
				open_q.delete(pick);
				v[w] = 1'b1;
			end
		end
		cdb_valid <= v;
		cdb_tag[0] <= tag[0];
		cdb_tag[1] <= tag[1];
	endtask

	task automatic run_cycle(input bit allow);
		@(negedge clock);
		cyc++;
		observe_results();
		observe_retire();
		@(posedge clock);
		drive_dispatch(allow);
		drive_completion();
	endtask

	initial begin
		seed_ret = $urandom(SEED);
		rst_n = 1'b0;
		disp_valid = '0;
		disp_dest = '0;
		cdb_valid = '0;
		cdb_tag = '0;
		cyc = 0;
		credits = rob_depth;
		dispatched_lanes = 0;
		retired_lanes = 0;
		zero_credit_cycles = 0;
		value_errs = 0;
		other_errs = 0;
		reset_model();
		repeat (2) begin   // Idle cycles around reset release
			grp_valid_q.push_back(2'b00);
			grp_dest_q.push_back(rename_pkg::ar_t'(0));
			grp_dest_q.push_back(rename_pkg::ar_t'(0));
		end
		repeat (4) @(posedge clock);
		rst_n <= 1'b1;
		repeat (RAND_CYCLES) run_cycle(1'b1);
		while (retired_lanes != dispatched_lanes) begin
			run_cycle(1'b0);
		end
		repeat (4) run_cycle(1'b0);   // Nothing may retire once drained
		if (rob_pr_q.size() != 0 || credits != rob_depth) begin
			other_errs++;
			$display("Drain incomplete: %0d entries left in the model, %0d of %0d credits back",
				rob_pr_q.size(), credits, rob_depth);
		end
		if (zero_credit_cycles == 0) begin
			other_errs++;
			$display("The ROB never filled up, so dispatch at zero credits was never tried");
		end
		$display("Lanes dispatched %0d, zero-credit cycles %0d",
			dispatched_lanes, zero_credit_cycles);
		$display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* flist.f */
+incdir+tests
common/rename_pkg.sv
verilog/map_table.sv
verilog/free_list.sv
rob/rob.sv
verilog/rename_core.sv
tests/tb_rename_core.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/1ns --top-module tb_rename_core \
	-f flist.f -Mdir obj_dir
out=$(./obj_dir/Vtb_rename_core) || true
echo "$out"
echo "$out" | grep -qx "TESTS PASSED"
